// ==== hw/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ------------------------------
// core widths
// ------------------------------

// data and pc width, the opcode decode assumes 32
`define CORE_XLEN 32

// architectural integer registers
`define CORE_REG_NUM 32

// register address width, log2 of the register count
`define CORE_REG_AW 5

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_pkg;

	// ------------------------------
	// opcodes and operations
	// ------------------------------

	// rv32i major opcodes handled by decode
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_imm    = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
	} br_cnd_e;

	// values follow funct3 of the load
	typedef enum logic [2:0] {
		sx_byte_s = 3'd0,
		sx_half_s = 3'd1,
		sx_word   = 3'd2,
		sx_byte_u = 3'd4,
		sx_half_u = 3'd5
	} wb_sx_op_e;

	typedef enum logic [2:0] {
		imm_i, imm_s, imm_b, imm_u, imm_j, imm_none
	} imm_fmt_e;

	// ------------------------------
	// operand and writeback selects
	// ------------------------------
	typedef enum logic [1:0] {opa_reg, opa_pc, opa_zero} op_a_e;
	typedef enum logic [1:0] {opb_reg, opb_imm} op_b_e;
	typedef enum logic [1:0] {wbs_alu, wbs_mem, wbs_pc_4} wb_src_e;

	typedef struct packed {
		op_a_e   op_a;
		op_b_e   op_b;
		wb_src_e wb_src;
	} src_sel_t;

	// cop set means store
	typedef struct packed {
		logic       val;
		logic       cop;
		logic [2:0] size;
	} l1d_req_t;

	typedef struct packed {
		alu_op_e   alu_op;
		br_cnd_e   br_cnd;
		wb_sx_op_e wb_sx_op;
		src_sel_t  src_sel;
		l1d_req_t  l1d_req;
		logic      we_rd;
		imm_fmt_e  imm_fmt;
		logic      uses_rs1;
		logic      uses_rs2;
		logic      legal;
	} dec_ctrl_t;

	typedef struct packed {
		logic                    we;
		logic [`CORE_REG_AW-1:0] rd;
		logic [`CORE_XLEN-1:0]   data;
	} wb_port_t;

	// registered output of the decode station
	typedef struct packed {
		alu_op_e                 alu_op;
		br_cnd_e                 br_cnd;
		wb_sx_op_e               wb_sx_op;
		src_sel_t                src_sel;
		l1d_req_t                l1d_req;
		logic                    we_rd;
		logic                    legal;
		logic [`CORE_XLEN-1:0]   src1;
		logic [`CORE_XLEN-1:0]   src2;
		logic [`CORE_XLEN-1:0]   imm;
		logic [`CORE_XLEN-1:0]   pc;
		logic [`CORE_XLEN-1:0]   pc_4;
		logic [`CORE_REG_AW-1:0] rs1;
		logic [`CORE_REG_AW-1:0] rs2;
		logic [`CORE_REG_AW-1:0] rd;
		logic                    val;
	} dec_out_t;

endpackage

`default_nettype wire

// ==== hw/core_cpu_ctrl.sv ====
`default_nettype none

`include "core_settings.svh"

module core_cpu_ctrl (
	input  logic [`CORE_XLEN-1:0] inst,
	output core_pkg::dec_ctrl_t   ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];

	// alu operation of op and op-imm, alt picks sub or sra
	function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		core_pkg::alu_op_e op;
		case (f3)
			3'd0:    op = alt ? core_pkg::alu_sub : core_pkg::alu_add;
			3'd1:    op = core_pkg::alu_sll;
			3'd2:    op = core_pkg::alu_slt;
			3'd3:    op = core_pkg::alu_sltu;
			3'd4:    op = core_pkg::alu_xor;
			3'd5:    op = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
			3'd6:    op = core_pkg::alu_or;
			default: op = core_pkg::alu_and;
		endcase
		return op;
	endfunction

	always_comb begin
		// defaults describe a harmless, not legal word
		ctrl                = '0;
		ctrl.alu_op         = core_pkg::alu_add;
		ctrl.br_cnd         = core_pkg::br_none;
		ctrl.wb_sx_op       = core_pkg::sx_word;
		ctrl.src_sel.op_a   = core_pkg::opa_reg;
		ctrl.src_sel.op_b   = core_pkg::opb_reg;
		ctrl.src_sel.wb_src = core_pkg::wbs_alu;
		ctrl.imm_fmt        = core_pkg::imm_none;

		case (core_pkg::opcode_e'(opcode))
			core_pkg::opc_lui: begin
				ctrl.legal        = 1'b1;
				ctrl.we_rd        = 1'b1;
				ctrl.alu_op       = core_pkg::alu_pass_b;
				ctrl.src_sel.op_a = core_pkg::opa_zero;
				ctrl.src_sel.op_b = core_pkg::opb_imm;
				ctrl.imm_fmt      = core_pkg::imm_u;
			end
			core_pkg::opc_auipc: begin
				ctrl.legal        = 1'b1;
				ctrl.we_rd        = 1'b1;
				ctrl.src_sel.op_a = core_pkg::opa_pc;
				ctrl.src_sel.op_b = core_pkg::opb_imm;
				ctrl.imm_fmt      = core_pkg::imm_u;
			end
			core_pkg::opc_jal: begin
				ctrl.legal          = 1'b1;
				ctrl.we_rd          = 1'b1;
				ctrl.br_cnd         = core_pkg::br_jump;
				ctrl.src_sel.op_a   = core_pkg::opa_pc;
				ctrl.src_sel.op_b   = core_pkg::opb_imm;
				ctrl.src_sel.wb_src = core_pkg::wbs_pc_4;
				ctrl.imm_fmt        = core_pkg::imm_j;
			end
			core_pkg::opc_jalr: begin
				ctrl.legal          = (funct3 == 3'd0);
				ctrl.we_rd          = 1'b1;
				ctrl.br_cnd         = core_pkg::br_jump;
				ctrl.src_sel.op_b   = core_pkg::opb_imm;
				ctrl.src_sel.wb_src = core_pkg::wbs_pc_4;
				ctrl.imm_fmt        = core_pkg::imm_i;
				ctrl.uses_rs1       = 1'b1;
			end
			core_pkg::opc_branch: begin
				ctrl.legal    = 1'b1;
				ctrl.alu_op   = core_pkg::alu_sub;
				ctrl.imm_fmt  = core_pkg::imm_b;
				ctrl.uses_rs1 = 1'b1;
				ctrl.uses_rs2 = 1'b1;
				case (funct3)
					3'd0:    ctrl.br_cnd = core_pkg::br_eq;
					3'd1:    ctrl.br_cnd = core_pkg::br_ne;
					3'd4:    ctrl.br_cnd = core_pkg::br_lt;
					3'd5:    ctrl.br_cnd = core_pkg::br_ge;
					3'd6:    ctrl.br_cnd = core_pkg::br_ltu;
					3'd7:    ctrl.br_cnd = core_pkg::br_geu;
					default: ctrl.legal  = 1'b0;
				endcase
			end
			core_pkg::opc_load: begin
				// lb lh lw lbu lhu only
				ctrl.legal          = (funct3 != 3'd3) && (funct3 < 3'd6);
				ctrl.we_rd          = 1'b1;
				ctrl.wb_sx_op       = core_pkg::wb_sx_op_e'(funct3);
				ctrl.src_sel.op_b   = core_pkg::opb_imm;
				ctrl.src_sel.wb_src = core_pkg::wbs_mem;
				ctrl.l1d_req.val    = 1'b1;
				ctrl.l1d_req.size   = {1'b0, funct3[1:0]};
				ctrl.imm_fmt        = core_pkg::imm_i;
				ctrl.uses_rs1       = 1'b1;
			end
			core_pkg::opc_store: begin
				ctrl.legal        = (funct3 < 3'd3);
				ctrl.src_sel.op_b = core_pkg::opb_imm;
				ctrl.l1d_req.val  = 1'b1;
				ctrl.l1d_req.cop  = 1'b1;
				ctrl.l1d_req.size = {1'b0, funct3[1:0]};
				ctrl.imm_fmt      = core_pkg::imm_s;
				ctrl.uses_rs1     = 1'b1;
				ctrl.uses_rs2     = 1'b1;
			end
			core_pkg::opc_imm: begin
				// shifts keep funct7 in the immediate field
				case (funct3)
					3'd1:    ctrl.legal = (funct7 == 7'b0000000);
					3'd5:    ctrl.legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					default: ctrl.legal = 1'b1;
				endcase
				ctrl.we_rd        = 1'b1;
				ctrl.alu_op       = alu_sel(funct3, (funct3 == 3'd5) && funct7[5]);
				ctrl.src_sel.op_b = core_pkg::opb_imm;
				ctrl.imm_fmt      = core_pkg::imm_i;
				ctrl.uses_rs1     = 1'b1;
			end
			core_pkg::opc_op: begin
				ctrl.legal = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
				ctrl.we_rd    = 1'b1;
				ctrl.alu_op   = alu_sel(funct3, funct7[5]);
				ctrl.uses_rs1 = 1'b1;
				ctrl.uses_rs2 = 1'b1;
			end
			default: ctrl.legal = 1'b0;
		endcase

		// no side effects from a bad word or a write to x0
		if (!ctrl.legal) begin
			ctrl.we_rd       = 1'b0;
			ctrl.l1d_req.val = 1'b0;
		end
		if (rd == 5'd0)
			ctrl.we_rd = 1'b0;
	end

endmodule

`default_nettype wire

// ==== hw/core_reg_file.sv ====
`default_nettype none

`include "core_settings.svh"

module core_reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`CORE_REG_AW-1:0] rs1,
	input  logic [`CORE_REG_AW-1:0] rs2,
	input  core_pkg::wb_port_t      wb,
	output logic [`CORE_XLEN-1:0]   src1,
	output logic [`CORE_XLEN-1:0]   src2
);

	logic [`CORE_XLEN-1:0] regs [`CORE_REG_NUM];

	// ------------------------------
	// write port
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_REG_NUM; i++)
				regs[i] <= '0;
		end else if (wb.we && (wb.rd != '0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// ------------------------------
	// read ports, write first
	// ------------------------------
	always_comb begin
		if (rs1 == '0)
			src1 = '0;
		else if (wb.we && (wb.rd == rs1))
			src1 = wb.data;
		else
			src1 = regs[rs1];

		if (rs2 == '0)
			src2 = '0;
		else if (wb.we && (wb.rd == rs2))
			src2 = wb.data;
		else
			src2 = regs[rs2];
	end

endmodule

`default_nettype wire

// ==== hw/core_imm_gen.sv ====
`default_nettype none

`include "core_settings.svh"

module core_imm_gen (
	input  logic [`CORE_XLEN-1:0] inst,
	input  core_pkg::imm_fmt_e    fmt,
	output logic [`CORE_XLEN-1:0] imm
);

	// sign always comes from bit 31
	logic sgn;

	assign sgn = inst[31];

	always_comb begin
		case (fmt)
			core_pkg::imm_i:
				imm = {{20{sgn}}, inst[31:20]};
			core_pkg::imm_s:
				imm = {{20{sgn}}, inst[31:25], inst[11:7]};
			// branch offsets are even
			core_pkg::imm_b:
				imm = {{19{sgn}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			core_pkg::imm_u:
				imm = {inst[31:12], 12'b0};
			core_pkg::imm_j:
				imm = {{11{sgn}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/core_haz_det.sv ====
`default_nettype none

`include "core_settings.svh"

module core_haz_det (
	input  logic [`CORE_REG_AW-1:0] cur_rs1,
	input  logic [`CORE_REG_AW-1:0] cur_rs2,
	input  logic                    cur_uses_rs1,
	input  logic                    cur_uses_rs2,
	input  core_pkg::dec_out_t      dec_out,
	input  logic                    l1i_ack,
	output logic                    stall
);

	logic ld_in_flight;
	logic hit_rs1;
	logic hit_rs2;
	logic load_use;

	// registered instruction is a valid load with a real target
	assign ld_in_flight = dec_out.val && dec_out.l1d_req.val && !dec_out.l1d_req.cop &&
		(dec_out.rd != '0);

	// only sources the current word really reads
	assign hit_rs1 = cur_uses_rs1 && (cur_rs1 == dec_out.rd);
	assign hit_rs2 = cur_uses_rs2 && (cur_rs2 == dec_out.rd);

	assign load_use = ld_in_flight && (hit_rs1 || hit_rs2);

	// missing fetch word holds decode too
	assign stall = !l1i_ack || load_use;

endmodule

`default_nettype wire

// ==== hw/core_dec_s.sv ====
`default_nettype none

`include "core_settings.svh"

module core_dec_s (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    dec_enb,
	input  logic                    dec_kill,
	input  logic [`CORE_XLEN-1:0]   inst,
	input  logic [`CORE_XLEN-1:0]   pc,
	input  logic [`CORE_XLEN-1:0]   pc_4,
	input  core_pkg::wb_port_t      wb,
	output core_pkg::dec_out_t      dec_out,
	output logic [`CORE_REG_AW-1:0] cur_rs1,
	output logic [`CORE_REG_AW-1:0] cur_rs2,
	output logic                    cur_uses_rs1,
	output logic                    cur_uses_rs2
);

	core_pkg::dec_ctrl_t   ctrl;
	core_pkg::dec_out_t    dec_nxt;
	logic [`CORE_REG_AW-1:0] rs1;
	logic [`CORE_REG_AW-1:0] rs2;
	logic [`CORE_REG_AW-1:0] rd;
	logic [`CORE_XLEN-1:0] src1;
	logic [`CORE_XLEN-1:0] src2;
	logic [`CORE_XLEN-1:0] imm;

	// register fields sit at fixed positions
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd  = inst[11:7];

	core_cpu_ctrl u_cpu_ctrl (
		.inst (inst),
		.ctrl (ctrl)
	);

	core_reg_file u_reg_file (
		.clk   (clk),
		.reset (reset),
		.rs1   (rs1),
		.rs2   (rs2),
		.wb    (wb),
		.src1  (src1),
		.src2  (src2)
	);

	core_imm_gen u_imm_gen (
		.inst (inst),
		.fmt  (ctrl.imm_fmt),
		.imm  (imm)
	);

	// current word for the hazard check
	assign cur_rs1      = rs1;
	assign cur_rs2      = rs2;
	assign cur_uses_rs1 = ctrl.uses_rs1;
	assign cur_uses_rs2 = ctrl.uses_rs2;

	// ------------------------------
	// next pipeline word
	// ------------------------------
	always_comb begin
		dec_nxt.alu_op   = ctrl.alu_op;
		dec_nxt.br_cnd   = ctrl.br_cnd;
		dec_nxt.wb_sx_op = ctrl.wb_sx_op;
		dec_nxt.src_sel  = ctrl.src_sel;
		dec_nxt.l1d_req  = ctrl.l1d_req;
		dec_nxt.we_rd    = ctrl.we_rd;
		dec_nxt.legal    = ctrl.legal;
		dec_nxt.src1     = src1;
		dec_nxt.src2     = src2;
		dec_nxt.imm      = imm;
		dec_nxt.pc       = pc;
		dec_nxt.pc_4     = pc_4;
		dec_nxt.rs1      = rs1;
		dec_nxt.rs2      = rs2;
		dec_nxt.rd       = rd;
		dec_nxt.val      = ctrl.legal;
	end

	// ------------------------------
	// decode register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			dec_out.val         <= 1'b0;
			dec_out.we_rd       <= 1'b0;
			dec_out.l1d_req.val <= 1'b0;
		end else if (dec_kill) begin
			// flush control only, data fields stay
			dec_out.alu_op   <= core_pkg::alu_add;
			dec_out.br_cnd   <= core_pkg::br_none;
			dec_out.wb_sx_op <= core_pkg::sx_byte_s;
			dec_out.src_sel  <= '0;
			dec_out.l1d_req  <= '0;
			dec_out.we_rd    <= 1'b0;
			dec_out.legal    <= 1'b0;
			dec_out.val      <= 1'b0;
		end else if (dec_enb) begin
			dec_out <= dec_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== hw/core_dec_top.sv ====
`default_nettype none

`include "core_settings.svh"

module core_dec_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dec_enb,
	input  logic                  dec_kill,
	input  logic                  l1i_ack,
	input  logic [`CORE_XLEN-1:0] inst,
	input  logic [`CORE_XLEN-1:0] pc,
	input  logic [`CORE_XLEN-1:0] pc_4,
	input  core_pkg::wb_port_t    wb,
	output core_pkg::dec_out_t    dec_out,
	output logic                  stall
);

	// current word sources, station to hazard detector
	logic [`CORE_REG_AW-1:0] cur_rs1;
	logic [`CORE_REG_AW-1:0] cur_rs2;
	logic                    cur_uses_rs1;
	logic                    cur_uses_rs2;

	core_dec_s u_dec_s (
		.clk          (clk),
		.reset        (reset),
		.dec_enb      (dec_enb),
		.dec_kill     (dec_kill),
		.inst         (inst),
		.pc           (pc),
		.pc_4         (pc_4),
		.wb           (wb),
		.dec_out      (dec_out),
		.cur_rs1      (cur_rs1),
		.cur_rs2      (cur_rs2),
		.cur_uses_rs1 (cur_uses_rs1),
		.cur_uses_rs2 (cur_uses_rs2)
	);

	core_haz_det u_haz_det (
		.cur_rs1      (cur_rs1),
		.cur_rs2      (cur_rs2),
		.cur_uses_rs1 (cur_uses_rs1),
		.cur_uses_rs2 (cur_uses_rs2),
		.dec_out      (dec_out),
		.l1i_ack      (l1i_ack),
		.stall        (stall)
	);

endmodule

`default_nettype wire

// ==== verification/core_dec_tb.sv ====
`default_nettype none

`include "core_settings.svh"

module core_dec_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_ROWS = 40;

	// dec_out check kinds
	localparam int M_RESET = 0;
	localparam int M_NEW   = 1;
	localparam int M_HOLD  = 2;
	localparam int M_KILL  = 3;

	localparam logic [6:0] OP_OP   = 7'b0110011;
	localparam logic [6:0] OP_IMM  = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;

	logic                    clk;
	logic                    reset;
	logic                    dec_enb;
	logic                    dec_kill;
	logic                    l1i_ack;
	logic [`CORE_XLEN-1:0]   inst;
	logic [`CORE_XLEN-1:0]   pc;
	logic [`CORE_XLEN-1:0]   pc_4;
	core_pkg::wb_port_t      wb;
	core_pkg::dec_out_t      dec_out;
	logic                    stall;

	// stimulus and expected values, one row per cycle
	string                 row_name  [MAX_ROWS];
	logic [31:0]           row_inst  [MAX_ROWS];
	logic                  row_enb   [MAX_ROWS];
	logic                  row_kill  [MAX_ROWS];
	logic                  row_ack   [MAX_ROWS];
	core_pkg::wb_port_t    row_wb    [MAX_ROWS];
	int                    row_mode  [MAX_ROWS];
	logic                  row_stall [MAX_ROWS];
	core_pkg::dec_out_t    row_exp   [MAX_ROWS];
	int                    n_rows;

	// reference register file
	logic [31:0]           model_regs [32];
	core_pkg::dec_out_t    staged;
	logic [31:0]           lcg_state;
	int                    cycle_cnt;
	int                    cycle_limit;

	core_dec_top u_core_dec_top (
		.clk      (clk),
		.reset    (reset),
		.dec_enb  (dec_enb),
		.dec_kill (dec_kill),
		.l1i_ack  (l1i_ack),
		.inst     (inst),
		.pc       (pc),
		.pc_4     (pc_4),
		.wb       (wb),
		.dec_out  (dec_out),
		.stall    (stall)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// control part of the next expected word
	task automatic set_exp(input core_pkg::alu_op_e alu, input core_pkg::br_cnd_e br,
		input core_pkg::wb_sx_op_e sx, input core_pkg::op_a_e opa, input core_pkg::op_b_e opb,
		input core_pkg::wb_src_e wbs, input logic [4:0] l1d, input logic we,
		input logic legal, input logic [31:0] imm);
		staged = '0;
		staged.alu_op          = alu;
		staged.br_cnd          = br;
		staged.wb_sx_op        = sx;
		staged.src_sel.op_a    = opa;
		staged.src_sel.op_b    = opb;
		staged.src_sel.wb_src  = wbs;
		staged.l1d_req         = l1d;
		staged.we_rd           = we;
		staged.legal           = legal;
		staged.val             = legal;
		staged.imm             = imm;
	endtask

	function automatic logic [31:0] model_read(input logic [4:0] rs, input core_pkg::wb_port_t w);
		if (rs == 5'd0)
			return 32'd0;
		if (w.we && (w.rd == rs))
			return w.data;
		return model_regs[rs];
	endfunction

	task automatic add_row(input string name, input logic [31:0] word, input logic enb,
		input logic kill, input logic ack, input logic wb_we, input logic [4:0] wb_rd,
		input int mode, input logic exp_stall);
		core_pkg::wb_port_t w;
		core_pkg::dec_out_t e;
		w.we   = wb_we;
		w.rd   = wb_rd;
		w.data = wb_we ? lcg_next() : 32'd0;
		case (mode)
			M_RESET: e = '0;
			M_HOLD:  e = row_exp[n_rows-1];
			M_KILL: begin
				e = row_exp[n_rows-1];
				e.alu_op   = core_pkg::alu_add;
				e.br_cnd   = core_pkg::br_none;
				e.wb_sx_op = core_pkg::sx_byte_s;
				e.src_sel  = '0;
				e.l1d_req  = '0;
				e.we_rd    = 1'b0;
				e.legal    = 1'b0;
				e.val      = 1'b0;
			end
			default: begin
				e      = staged;
				e.src1 = model_read(word[19:15], w);
				e.src2 = model_read(word[24:20], w);
				e.pc   = 32'h1000 + 32'(n_rows * 4);
				e.pc_4 = e.pc + 32'd4;
				e.rs1  = word[19:15];
				e.rs2  = word[24:20];
				e.rd   = word[11:7];
			end
		endcase
		if (wb_we && (wb_rd != 5'd0))
			model_regs[wb_rd] = w.data;
		row_name[n_rows]  = name;
		row_inst[n_rows]  = word;
		row_enb[n_rows]   = enb;
		row_kill[n_rows]  = kill;
		row_ack[n_rows]   = ack;
		row_wb[n_rows]    = w;
		row_mode[n_rows]  = mode;
		row_stall[n_rows] = exp_stall;
		row_exp[n_rows]   = e;
		n_rows++;
	endtask

	task automatic fail_run();
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_dec_out(input string name, input core_pkg::dec_out_t exp,
		input core_pkg::dec_out_t act);
		if (act !== exp) begin
			$display("Fail %s: dec_out expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_stall(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: stall expected %b actual %b", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_row(input int i);
		core_pkg::dec_out_t act;
		act = dec_out;
		// after reset only val, we_rd and the request valid are defined
		if (row_mode[i] == M_RESET) begin
			act = row_exp[i];
			act.val         = dec_out.val;
			act.we_rd       = dec_out.we_rd;
			act.l1d_req.val = dec_out.l1d_req.val;
		end
		check_dec_out(row_name[i], row_exp[i], act);
	endtask

	// ------------------------------
	// table
	// ------------------------------
	task automatic build_table();
		add_row("reset_state", 32'd0, 0, 0, 1, 1, 5'd5, M_RESET, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'd0);
		add_row("rf_zero_read", enc_r(0, 9, 8, 0, 7, OP_OP), 1, 0, 1, 1, 5'd6, M_NEW, 0);
		add_row("add_bypass", enc_r(0, 6, 5, 0, 3, OP_OP), 1, 0, 1, 1, 5'd6, M_NEW, 0);
		set_exp(core_pkg::alu_sub, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'd0);
		add_row("sub_x0_write", enc_r(7'b0100000, 5, 6, 0, 4, OP_OP), 1, 0, 1, 1, 5'd0,
			M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'd0);
		add_row("x0_read", enc_r(0, 0, 0, 0, 10, OP_OP), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b00000, 1, 1, -32'sd5);
		add_row("addi_neg", enc_i(-32'sd5, 5, 0, 11, OP_IMM), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_sra, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'h403);
		add_row("srai", enc_i(32'h403, 6, 5, 12, OP_IMM), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_pass_b, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_zero,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'h80001000);
		add_row("lui", enc_u(20'h80001, 13, 7'b0110111), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_pc,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'h12345000);
		add_row("auipc", enc_u(20'h12345, 14, 7'b0010111), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_jump, core_pkg::sx_word, core_pkg::opa_pc,
			core_pkg::opb_imm, core_pkg::wbs_pc_4, 5'b00000, 1, 1, -32'sd2048);
		add_row("jal_neg", enc_j(-32'sd2048, 1), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		// positive offset with mixed bits, link to x0 writes nothing
		set_exp(core_pkg::alu_add, core_pkg::br_jump, core_pkg::sx_word, core_pkg::opa_pc,
			core_pkg::opb_imm, core_pkg::wbs_pc_4, 5'b00000, 0, 1, 32'h00055AAA);
		add_row("jal_pos_x0", enc_j(32'h00055AAA, 0), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_jump, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_pc_4, 5'b00000, 1, 1, 32'd100);
		add_row("jalr", enc_i(32'd100, 5, 0, 1, 7'b1100111), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_sub, core_pkg::br_eq, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 0, 1, -32'sd16);
		add_row("beq_neg", enc_b(-32'sd16, 6, 5, 0), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_sub, core_pkg::br_ltu, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 0, 1, 32'd2046);
		add_row("bltu", enc_b(32'd2046, 6, 5, 6), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b11010, 0, 1, -32'sd4);
		add_row("sw", enc_s(-32'sd4, 6, 5, 2), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b11000, 0, 1, 32'd7);
		add_row("sb", enc_s(32'd7, 6, 5, 0), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_half_u, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_mem, 5'b10001, 1, 1, -32'sd2);
		add_row("lhu", enc_i(-32'sd2, 5, 5, 15, OP_LOAD), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_byte_s, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_mem, 5'b10000, 1, 1, 32'd0);
		add_row("lb", enc_i(32'd0, 5, 0, 16, OP_LOAD), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		// reads x16 right behind the load of x16
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'd0);
		add_row("load_use", enc_r(0, 6, 16, 0, 17, OP_OP), 1, 0, 1, 0, 5'd0, M_NEW, 1);
		add_row("enb_hold", enc_i(32'd1, 1, 0, 1, OP_IMM), 0, 0, 1, 0, 5'd0, M_HOLD, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_mem, 5'b10010, 0, 1, 32'd8);
		add_row("lw_rd0", enc_i(32'd8, 5, 2, 0, OP_LOAD), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'd0);
		add_row("use_x0", enc_r(0, 6, 0, 0, 18, OP_OP), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_mem, 5'b10010, 1, 1, 32'd0);
		add_row("lw_x20", enc_i(32'd0, 6, 2, 20, OP_LOAD), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		// rs1 field holds 20 but lui reads no register
		set_exp(core_pkg::alu_pass_b, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_zero,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'h000A0000);
		add_row("unused_src", enc_u(20'h000A0, 21, 7'b0110111), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'd1);
		add_row("fetch_miss", enc_i(32'd1, 0, 0, 1, OP_IMM), 1, 0, 0, 0, 5'd0, M_NEW, 1);
		add_row("kill", enc_r(0, 6, 5, 0, 2, OP_OP), 1, 1, 1, 0, 5'd0, M_KILL, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_reg, core_pkg::wbs_alu, 5'b00000, 0, 0, 32'd0);
		add_row("bad_opcode", enc_r(0, 7, 6, 0, 5, 7'b0001011), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		add_row("bad_funct7", enc_r(7'b0000001, 6, 5, 0, 7, OP_OP), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		// doubleword store is not rv32i, its request must not be valid
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b01011, 0, 0, 32'd12);
		add_row("bad_store", enc_s(32'd12, 6, 5, 3), 1, 0, 1, 0, 5'd0, M_NEW, 0);
		set_exp(core_pkg::alu_add, core_pkg::br_none, core_pkg::sx_word, core_pkg::opa_reg,
			core_pkg::opb_imm, core_pkg::wbs_alu, 5'b00000, 1, 1, 32'd1);
		add_row("last", enc_i(32'd1, 0, 0, 1, OP_IMM), 1, 0, 1, 0, 5'd0, M_NEW, 0);
	endtask

	// ------------------------------
	// run
	// ------------------------------
	always @(posedge clk) begin
		cycle_cnt++;
		if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
			$display("timeout: the test sequence ran past %0d cycles", cycle_limit);
			fail_run();
		end
	end

	initial begin
		reset       = 1'b1;
		// a legal load and a register write while reset is high
		dec_enb     = 1'b1;
		dec_kill    = 1'b0;
		l1i_ack     = 1'b1;
		inst        = enc_i(32'd0, 5'd5, 3'd2, 5'd9, OP_LOAD);
		pc          = '0;
		pc_4        = '0;
		wb.we       = 1'b1;
		wb.rd       = 5'd8;
		wb.data     = 32'hFFFF_FFFF;
		cycle_cnt   = 0;
		cycle_limit = 0;
		n_rows      = 0;
		lcg_state   = 32'd87;
		for (int r = 0; r < 32; r++)
			model_regs[r] = 32'd0;
		build_table();
		cycle_limit = n_rows + 2 + 20;

		repeat (2) @(posedge clk);
		for (int i = 0; i < n_rows; i++) begin
			if (i > 0)
				@(posedge clk);
			#5;
			reset    = 1'b0;
			inst     = row_inst[i];
			pc       = 32'h1000 + 32'(i * 4);
			pc_4     = 32'h1004 + 32'(i * 4);
			dec_enb  = row_enb[i];
			dec_kill = row_kill[i];
			l1i_ack  = row_ack[i];
			wb       = row_wb[i];
			#40;
			check_stall(row_name[i], row_stall[i], stall);
			if (i > 0)
				check_row(i - 1);
		end
		@(posedge clk);
		#45;
		check_row(n_rows - 1);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== selen_dec.f ====
+incdir+hw
hw/core_pkg.sv
hw/core_cpu_ctrl.sv
hw/core_reg_file.sv
hw/core_imm_gen.sv
hw/core_haz_det.sv
hw/core_dec_s.sv
hw/core_dec_top.sv
verification/core_dec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f selen_dec.f --top-module core_dec_tb \
	--Mdir obj_dir -o core_dec_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/core_dec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if grep -q "All tests passed" sim.log; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
